/* rtl/wb_pkg.sv */
package wb_pkg;

    // data width of the integer datapath
    localparam int xlen = 64;

    // load kinds, decoded in the memory stage
    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_H  = 3'd1,
        LD_W  = 3'd2,
        LD_D  = 3'd3,
        LD_BU = 3'd4,
        LD_HU = 3'd5,
        LD_WU = 3'd6
    } ld_size_e;

    // where the rd value comes from
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_CSR = 2'd2,
        WB_PC4 = 2'd3
    } wb_src_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_TRAP  = 2'd2,
        CSR_MRET  = 2'd3
    } csr_op_e;

    // machine mode csr addresses
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    // one instruction handed over by the memory stage
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
        logic [xlen-1:0] alu_out;
        logic [xlen-1:0] mem_data;
        ld_size_e        ld_size;
        logic [2:0]      byte_off;
        logic [4:0]      rd;
        logic            reg_wen;
        wb_src_e         wb_src;
        csr_op_e         csr_op;
        logic [11:0]     csr_addr;
        logic [xlen-1:0] csr_old;
        logic [xlen-1:0] trap_cause;
    } wb_item_t;

    // retired instruction as seen by the commit consumer
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
        logic [4:0]      rd;
        logic            rd_wen;
        logic [xlen-1:0] rd_data;
    } commit_t;

endpackage

/* rtl/mem_wb_reg.sv */
`timescale 1ns/10ps

module mem_wb_reg import wb_pkg::*; (
    input  logic     I_sys_clk,
    input  logic     I_rst,
    input  logic     in_valid,
    input  wb_item_t in_item,
    input  logic     retire,
    output logic     allowin,
    output logic     stage_valid,
    output wb_item_t stage_item
);

    // free slot, or the held item leaves this cycle
    assign allowin = !stage_valid || retire;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            stage_valid <= 1'b0;
        end else if (allowin) begin
            stage_valid <= in_valid;
        end
    end

    // payload only, the valid bit qualifies it
    always_ff @(posedge I_sys_clk) begin
        if (allowin && in_valid) begin
            stage_item <= in_item;
        end
    end

    // held item must not move under a stalled consumer
    assert property (@(posedge I_sys_clk) disable iff (I_rst)
        stage_valid && !retire |=> $stable(stage_item))
        else $error("mem_wb_reg: item changed while stalled");

endmodule

/* rtl/wb_ctrl.sv */
`timescale 1ns/10ps

module wb_ctrl import wb_pkg::*; (
    input  logic     stage_valid,
    input  wb_item_t stage_item,
    input  logic     commit_ready,
    output logic     retire,
    output logic     rf_wen,
    output csr_op_e  csr_cmd,
    output logic     redirect_valid
);

    logic is_flow_change;

    // the commit consumer is the only thing that can stall the stage
    assign retire = stage_valid && commit_ready;

    // writes to x0 are dropped here as well as in the file
    assign rf_wen = retire && stage_item.reg_wen && (stage_item.rd != 5'd0);

    assign csr_cmd = retire ? stage_item.csr_op : CSR_NONE;

    assign is_flow_change = (stage_item.csr_op == CSR_TRAP) ||
                            (stage_item.csr_op == CSR_MRET);

    // single pulse, the item leaves on the same edge
    assign redirect_valid = retire && is_flow_change;

    always_comb begin
        assert (!redirect_valid || (stage_valid && commit_ready))
            else $error("wb_ctrl: redirect without retire");
    end

endmodule

/* rtl/load_align.sv */
`timescale 1ns/10ps

module load_align import wb_pkg::*; (
    input  logic [xlen-1:0] mem_data,
    input  ld_size_e        ld_size,
    input  logic [2:0]      byte_off,
    output logic [xlen-1:0] load_value
);

    logic [xlen-1:0] shifted;

    // bring the addressed byte down to bit 0
    assign shifted = mem_data >> {byte_off, 3'b000};

    always_comb begin
        unique case (ld_size)
            LD_B: begin
                load_value = {{56{shifted[7]}}, shifted[7:0]};
            end
            LD_H: begin
                load_value = {{48{shifted[15]}}, shifted[15:0]};
            end
            LD_W: begin
                load_value = {{32{shifted[31]}}, shifted[31:0]};
            end
            LD_BU: begin
                load_value = {56'd0, shifted[7:0]};
            end
            LD_HU: begin
                load_value = {48'd0, shifted[15:0]};
            end
            LD_WU: begin
                load_value = {32'd0, shifted[31:0]};
            end
            // full doubleword, offset is zero
            default: begin
                load_value = shifted;
            end
        endcase
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/10ps

module reg_file import wb_pkg::*; (
    input  logic            I_sys_clk,
    input  logic            I_rst,
    input  logic            wen,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata,
    input  logic [4:0]      rs1_addr,
    output logic [xlen-1:0] rs1_data,
    input  logic [4:0]      rs2_addr,
    output logic [xlen-1:0] rs2_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass, a write shows up the cycle after
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

/* rtl/csr_file.sv */
`timescale 1ns/10ps

module csr_file import wb_pkg::*; #(
    parameter logic [xlen-1:0] MTVEC_RESET = 64'h8000_0000
) (
    input  logic            I_sys_clk,
    input  logic            I_rst,
    input  csr_op_e         csr_cmd,
    input  logic [11:0]     csr_addr,
    input  logic [xlen-1:0] wdata,
    input  logic [xlen-1:0] trap_pc,
    input  logic [xlen-1:0] trap_cause,
    input  logic [11:0]     csr_raddr,
    output logic [xlen-1:0] csr_rdata,
    output logic [xlen-1:0] redirect_pc
);

    logic            mie;
    logic            mpie;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mstatus;

    // only MIE (bit 3) and MPIE (bit 7) are implemented
    always_comb begin
        mstatus    = '0;
        mstatus[3] = mie;
        mstatus[7] = mpie;
    end

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mie      <= 1'b0;
            mpie     <= 1'b0;
            mtvec    <= MTVEC_RESET;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else begin
            unique case (csr_cmd)
                CSR_WRITE: begin
                    // unknown addresses fall through untouched
                    case (csr_addr)
                        CSR_MSTATUS: begin
                            mie  <= wdata[3];
                            mpie <= wdata[7];
                        end
                        CSR_MTVEC:    mtvec    <= wdata;
                        CSR_MEPC:     mepc     <= wdata;
                        CSR_MCAUSE:   mcause   <= wdata;
                        CSR_MSCRATCH: mscratch <= wdata;
                        default: ;
                    endcase
                end
                CSR_TRAP: begin
                    mepc   <= trap_pc;
                    mcause <= trap_cause;
                    mpie   <= mie;
                    mie    <= 1'b0;
                end
                CSR_MRET: begin
                    mie  <= mpie;
                    mpie <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (csr_raddr)
            CSR_MSTATUS:  csr_rdata = mstatus;
            CSR_MTVEC:    csr_rdata = mtvec;
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MCAUSE:   csr_rdata = mcause;
            CSR_MSCRATCH: csr_rdata = mscratch;
            default:      csr_rdata = '0;
        endcase
    end

    // current register values, before this cycle's update lands
    assign redirect_pc = (csr_cmd == CSR_TRAP) ? mtvec : mepc;

endmodule

/* rtl/wb_top.sv */
`timescale 1ns/10ps

module wb_top import wb_pkg::*; #(
    parameter logic [xlen-1:0] MTVEC_RESET = 64'h8000_0000
) (
    input  logic            I_sys_clk,
    input  logic            I_rst,
    input  logic            in_valid,
    input  wb_item_t        in_item,
    output logic            allowin,
    input  logic            commit_ready,
    output logic            commit_valid,
    output commit_t         commit,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc,
    input  logic [4:0]      rs1_addr,
    output logic [xlen-1:0] rs1_data,
    input  logic [4:0]      rs2_addr,
    output logic [xlen-1:0] rs2_data,
    input  logic [11:0]     csr_raddr,
    output logic [xlen-1:0] csr_rdata
);

    logic            stage_valid;
    wb_item_t        stage_item;
    logic            retire;
    logic            rf_wen;
    csr_op_e         csr_cmd;
    logic [xlen-1:0] load_value;
    logic [xlen-1:0] rd_value;
    logic            load_aligned;

    mem_wb_reg u_mem_wb_reg (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .in_valid    (in_valid),
        .in_item     (in_item),
        .retire      (retire),
        .allowin     (allowin),
        .stage_valid (stage_valid),
        .stage_item  (stage_item)
    );

    wb_ctrl u_wb_ctrl (
        .stage_valid    (stage_valid),
        .stage_item     (stage_item),
        .commit_ready   (commit_ready),
        .retire         (retire),
        .rf_wen         (rf_wen),
        .csr_cmd        (csr_cmd),
        .redirect_valid (redirect_valid)
    );

    load_align u_load_align (
        .mem_data   (stage_item.mem_data),
        .ld_size    (stage_item.ld_size),
        .byte_off   (stage_item.byte_off),
        .load_value (load_value)
    );

    // rd value by writeback source
    always_comb begin
        unique case (stage_item.wb_src)
            WB_MEM:  rd_value = load_value;
            WB_CSR:  rd_value = stage_item.csr_old;
            WB_PC4:  rd_value = stage_item.pc + 64'd4;
            default: rd_value = stage_item.alu_out;
        endcase
    end

    reg_file u_reg_file (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .wen       (rf_wen),
        .waddr     (stage_item.rd),
        .wdata     (rd_value),
        .rs1_addr  (rs1_addr),
        .rs1_data  (rs1_data),
        .rs2_addr  (rs2_addr),
        .rs2_data  (rs2_data)
    );

    // csr write value comes precomputed in alu_out
    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr_file (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .csr_cmd     (csr_cmd),
        .csr_addr    (stage_item.csr_addr),
        .wdata       (stage_item.alu_out),
        .trap_pc     (stage_item.pc),
        .trap_cause  (stage_item.trap_cause),
        .csr_raddr   (csr_raddr),
        .csr_rdata   (csr_rdata),
        .redirect_pc (redirect_pc)
    );

    assign commit_valid   = stage_valid;
    assign commit.pc      = stage_item.pc;
    assign commit.inst    = stage_item.inst;
    assign commit.rd      = stage_item.rd;
    assign commit.rd_wen  = stage_item.reg_wen;
    assign commit.rd_data = rd_value;

    // natural alignment of the load held in the stage
    always_comb begin
        case (stage_item.ld_size)
            LD_H, LD_HU: load_aligned = (stage_item.byte_off[0] == 1'b0);
            LD_W, LD_WU: load_aligned = (stage_item.byte_off[1:0] == 2'b00);
            LD_D:        load_aligned = (stage_item.byte_off == 3'b000);
            default:     load_aligned = 1'b1;
        endcase
    end

    assert property (@(posedge I_sys_clk) disable iff (I_rst)
        stage_valid && (stage_item.wb_src == WB_MEM) |-> load_aligned)
        else $error("wb_top: misaligned load reached writeback");

endmodule

/* verif/wb_tests.svh */
`ifndef WB_TESTS_SVH
`define WB_TESTS_SVH

function automatic int access_bytes(input ld_size_e kind);
    case (kind)
        LD_B, LD_BU: return 1;
        LD_H, LD_HU: return 2;
        LD_W, LD_WU: return 4;
        default:     return 8;
    endcase
endfunction

// byte-wise pick at the offset, then fill the upper bytes
function automatic logic [63:0] expected_load(input logic [63:0] word, input ld_size_e kind,
                                              input int off);
    logic [63:0] r;
    int n;
    logic sgn;
    r = '0;
    n = access_bytes(kind);
    sgn = (kind == LD_B) || (kind == LD_H) || (kind == LD_W);
    for (int i = 0; i < 8; i++) begin
        if (i < n) begin
            r[i*8 +: 8] = word[(off + i)*8 +: 8];
        end else begin
            r[i*8 +: 8] = sgn ? {8{r[n*8-1]}} : 8'h00;
        end
    end
    return r;
endfunction

task automatic test_alu_writeback();
    int errs0;
    wb_item_t it;
    commit_t c;
    logic rv;
    logic [63:0] rpc;
    logic [4:0] dests [4];
    errs0 = errors;
    dests = '{5'd5, 5'd12, 5'd31, 5'd0};
    @(negedge I_sys_clk);
    if (!allowin || commit_valid || redirect_valid) begin
        $display("state after reset is wrong: allowin %b commit_valid %b redirect_valid %b",
                 allowin, commit_valid, redirect_valid);
        errors++;
    end
    foreach (dests[i]) begin
        it = make_item();
        it.rd = dests[i];
        it.reg_wen = 1'b1;
        it.alu_out = {$urandom, $urandom};
        offer(it);
        take_commit(c, rv, rpc);
        if (c.pc !== it.pc) report_mismatch("commit.pc", c.pc, it.pc);
        if (c.inst !== it.inst) report_mismatch("commit.inst", 64'(c.inst), 64'(it.inst));
        if (c.rd !== it.rd) report_mismatch("commit.rd", 64'(c.rd), 64'(it.rd));
        if (c.rd_wen !== it.reg_wen) begin
            report_mismatch("commit.rd_wen", 64'(c.rd_wen), 64'(it.reg_wen));
        end
        if (c.rd_data !== it.alu_out) report_mismatch("commit.rd_data", c.rd_data, it.alu_out);
        if (rv !== 1'b0) report_mismatch("redirect_valid", 64'(rv), 64'd0);
        // x0 commits but keeps reading zero
        if (it.rd != 5'd0) model[it.rd] = it.alu_out;
        check_regs(it.rd, dests[0]);
    end
    finish_test("alu_writeback", errs0);
endtask

task automatic test_loads();
    int errs0;
    int n;
    wb_item_t it;
    commit_t c;
    logic rv;
    logic [63:0] rpc;
    logic [63:0] word;
    logic [63:0] exp;
    errs0 = errors;
    word = {$urandom, $urandom};
    for (int k = 0; k < 7; k++) begin
        n = access_bytes(ld_size_e'(k));
        for (int off = 0; off < 8; off += n) begin
            it = make_item();
            it.wb_src = WB_MEM;
            it.mem_data = word;
            it.ld_size = ld_size_e'(k);
            it.byte_off = 3'(off);
            it.rd = 5'd7;
            it.reg_wen = 1'b1;
            exp = expected_load(word, it.ld_size, off);
            offer(it);
            take_commit(c, rv, rpc);
            if (c.rd_data !== exp) report_mismatch("commit.rd_data", c.rd_data, exp);
            model[7] = exp;
        end
    end
    check_regs(5'd7, 5'd7);
    finish_test("loads", errs0);
endtask

task automatic test_backpressure();
    int errs0;
    wb_item_t a;
    wb_item_t b;
    commit_t c;
    commit_t held;
    logic rv;
    logic [63:0] rpc;
    errs0 = errors;
    a = make_item();
    a.rd = 5'd9;
    a.reg_wen = 1'b1;
    a.alu_out = {$urandom, $urandom};
    b = make_item();
    b.rd = 5'd10;
    b.reg_wen = 1'b1;
    b.alu_out = {$urandom, $urandom};
    @(posedge I_sys_clk);
    commit_ready <= 1'b0;
    offer(a);
    // second item waits at the input
    in_item <= b;
    in_valid <= 1'b1;
    rs1_addr <= a.rd;
    @(negedge I_sys_clk);
    held = commit;
    if (held.pc !== a.pc) report_mismatch("commit.pc", held.pc, a.pc);
    repeat (3) begin
        if (allowin !== 1'b0) begin
            $display("allowin went high while the consumer stalled");
            errors++;
        end
        if (commit_valid !== 1'b1 || commit !== held) begin
            $display("commit port moved while the consumer stalled");
            errors++;
        end
        if (rs1_data !== model[a.rd]) report_mismatch("rs1_data", rs1_data, model[a.rd]);
        @(negedge I_sys_clk);
    end
    @(posedge I_sys_clk);
    commit_ready <= 1'b1;
    take_commit(c, rv, rpc);
    in_valid <= 1'b0;
    if (c.pc !== a.pc) report_mismatch("commit.pc", c.pc, a.pc);
    if (c.rd_data !== a.alu_out) report_mismatch("commit.rd_data", c.rd_data, a.alu_out);
    model[a.rd] = a.alu_out;
    take_commit(c, rv, rpc);
    if (c.pc !== b.pc) report_mismatch("commit.pc", c.pc, b.pc);
    if (c.rd_data !== b.alu_out) report_mismatch("commit.rd_data", c.rd_data, b.alu_out);
    model[b.rd] = b.alu_out;
    check_regs(a.rd, b.rd);
    @(negedge I_sys_clk);
    if (commit_valid) begin
        $display("extra commit after both items retired");
        errors++;
    end
    @(posedge I_sys_clk);
    finish_test("backpressure", errs0);
endtask

task automatic test_csr_write();
    int errs0;
    wb_item_t it;
    commit_t c;
    logic rv;
    logic [63:0] rpc;
    logic [63:0] data;
    errs0 = errors;
    it = make_item();
    it.csr_op = CSR_WRITE;
    it.csr_addr = CSR_MSCRATCH;
    it.alu_out = {$urandom, $urandom};
    it.csr_old = {$urandom, $urandom};
    it.wb_src = WB_CSR;
    it.rd = 5'd14;
    it.reg_wen = 1'b1;
    offer(it);
    take_commit(c, rv, rpc);
    if (c.rd_data !== it.csr_old) report_mismatch("commit.rd_data", c.rd_data, it.csr_old);
    model[14] = it.csr_old;
    read_csr(CSR_MSCRATCH, data);
    if (data !== it.alu_out) report_mismatch("csr_rdata", data, it.alu_out);
    check_regs(5'd14, 5'd14);
    finish_test("csr_write", errs0);
endtask

task automatic test_trap_mret();
    int errs0;
    wb_item_t it;
    wb_item_t t;
    commit_t c;
    logic rv;
    logic [63:0] rpc;
    logic [63:0] data;
    errs0 = errors;
    // MIE on, MPIE off before the trap
    it = make_item();
    it.csr_op = CSR_WRITE;
    it.csr_addr = CSR_MSTATUS;
    it.alu_out = 64'h8;
    offer(it);
    take_commit(c, rv, rpc);
    t = make_item();
    t.csr_op = CSR_TRAP;
    t.trap_cause = {$urandom, $urandom};
    offer(t);
    take_commit(c, rv, rpc);
    if (rv !== 1'b1) report_mismatch("redirect_valid", 64'(rv), 64'd1);
    if (rpc !== mtvec_reset) report_mismatch("redirect_pc", rpc, mtvec_reset);
    if (c.rd_wen !== t.reg_wen) begin
        report_mismatch("commit.rd_wen", 64'(c.rd_wen), 64'(t.reg_wen));
    end
    csr_raddr <= CSR_MEPC;
    @(negedge I_sys_clk);
    if (redirect_valid) begin
        $display("redirect_valid stayed high after the trap retired");
        errors++;
    end
    if (csr_rdata !== t.pc) report_mismatch("mepc", csr_rdata, t.pc);
    @(posedge I_sys_clk);
    read_csr(CSR_MCAUSE, data);
    if (data !== t.trap_cause) report_mismatch("mcause", data, t.trap_cause);
    read_csr(CSR_MSTATUS, data);
    if (data !== 64'h80) report_mismatch("mstatus", data, 64'h80);
    it = make_item();
    it.csr_op = CSR_MRET;
    offer(it);
    take_commit(c, rv, rpc);
    if (rv !== 1'b1) report_mismatch("redirect_valid", 64'(rv), 64'd1);
    if (rpc !== t.pc) report_mismatch("redirect_pc", rpc, t.pc);
    read_csr(CSR_MSTATUS, data);
    if (data !== 64'h88) report_mismatch("mstatus", data, 64'h88);
    finish_test("trap_mret", errs0);
endtask

task automatic test_link();
    int errs0;
    wb_item_t it;
    commit_t c;
    logic rv;
    logic [63:0] rpc;
    errs0 = errors;
    it = make_item();
    it.wb_src = WB_PC4;
    it.alu_out = {$urandom, $urandom};
    it.rd = 5'd1;
    it.reg_wen = 1'b1;
    offer(it);
    take_commit(c, rv, rpc);
    if (c.rd_data !== it.pc + 64'd4) report_mismatch("commit.rd_data", c.rd_data, it.pc + 64'd4);
    model[1] = it.pc + 64'd4;
    check_regs(5'd1, 5'd1);
    finish_test("link", errs0);
endtask

`endif

/* verif/tb_wb_top.sv */
`timescale 1ns/10ps

module tb_wb_top import wb_pkg::*; ();

    localparam int clk_period = 40;
    localparam int num_tests = 6;
    localparam logic [xlen-1:0] mtvec_reset = 64'h0000_0000_8000_0100;

    logic            I_sys_clk;
    logic            I_rst;
    logic            in_valid;
    wb_item_t        in_item;
    logic            allowin;
    logic            commit_ready;
    logic            commit_valid;
    commit_t         commit;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;
    logic [4:0]      rs1_addr;
    logic [xlen-1:0] rs1_data;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs2_data;
    logic [11:0]     csr_raddr;
    logic [xlen-1:0] csr_rdata;

    int errors;
    int tests_run;
    int tests_failed;

    // expected integer register contents
    logic [xlen-1:0] model [32];

    wb_top #(
        .MTVEC_RESET (mtvec_reset)
    ) UUT (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .in_valid       (in_valid),
        .in_item        (in_item),
        .allowin        (allowin),
        .commit_ready   (commit_ready),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .rs1_addr       (rs1_addr),
        .rs1_data       (rs1_data),
        .rs2_addr       (rs2_addr),
        .rs2_data       (rs2_data),
        .csr_raddr      (csr_raddr),
        .csr_rdata      (csr_rdata)
    );

    always #(clk_period / 2) I_sys_clk = ~I_sys_clk;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("error: %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // neutral ALU item at a random word-aligned pc
    function automatic wb_item_t make_item();
        wb_item_t it;
        it = '0;
        it.pc = {$urandom, $urandom & 32'hffff_fffc};
        it.inst = $urandom;
        it.ld_size = LD_D;
        it.wb_src = WB_ALU;
        it.csr_op = CSR_NONE;
        return it;
    endfunction

    // called at a rising edge, returns at the transfer edge
    task automatic offer(input wb_item_t it);
        @(posedge I_sys_clk);
        in_item <= it;
        in_valid <= 1'b1;
        @(negedge I_sys_clk);
        while (!allowin) @(negedge I_sys_clk);
        @(posedge I_sys_clk);
        in_valid <= 1'b0;
    endtask

    // snapshot at mid cycle, returns at the retire edge
    task automatic take_commit(output commit_t c, output logic redir,
                               output logic [63:0] redir_pc);
        @(negedge I_sys_clk);
        while (!(commit_valid && commit_ready)) @(negedge I_sys_clk);
        c = commit;
        redir = redirect_valid;
        redir_pc = redirect_pc;
        @(posedge I_sys_clk);
    endtask

    task automatic check_regs(input logic [4:0] r1, input logic [4:0] r2);
        rs1_addr <= r1;
        rs2_addr <= r2;
        @(negedge I_sys_clk);
        if (rs1_data !== model[r1]) report_mismatch("rs1_data", rs1_data, model[r1]);
        if (rs2_data !== model[r2]) report_mismatch("rs2_data", rs2_data, model[r2]);
        @(posedge I_sys_clk);
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [63:0] data);
        csr_raddr <= addr;
        @(negedge I_sys_clk);
        data = csr_rdata;
        @(posedge I_sys_clk);
    endtask

    `include "wb_tests.svh"

    initial begin
        void'($urandom(32'he653_bc12));
        I_sys_clk = 1'b0;
        I_rst = 1'b1;
        in_valid = 1'b0;
        in_item = '0;
        commit_ready = 1'b1;
        rs1_addr = '0;
        rs2_addr = '0;
        csr_raddr = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        foreach (model[i]) model[i] = '0;
        repeat (4) @(posedge I_sys_clk);
        I_rst <= 1'b0;
        test_alu_writeback();
        test_loads();
        test_backpressure();
        test_csr_write();
        test_trap_mret();
        test_link();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // 200 cycles per test is far more than any test needs
    initial begin
        #(num_tests * 200 * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+verif
rtl/wb_pkg.sv
rtl/mem_wb_reg.sv
rtl/wb_ctrl.sv
rtl/load_align.sv
rtl/reg_file.sv
rtl/csr_file.sv
rtl/wb_top.sv
verif/tb_wb_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --timing --assert -sv
TOP       = tb_wb_top
FILELIST  = files.f
BUILD     = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)
	@out="$$(./$(BUILD)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD)
